/* source/soc_bus_pkg.sv */
// ===================================================================
// Peripheral bus shared definitions
// ===================================================================
`default_nettype none

package soc_bus_pkg;

  // Bus widths
  parameter int addr_w = 32;
  parameter int data_w = 64;

  // Access size codes on the 3-bit size field
  parameter logic [2:0] size_byte  = 3'd0;
  parameter logic [2:0] size_half  = 3'd1;
  parameter logic [2:0] size_word  = 3'd2;
  parameter logic [2:0] size_dword = 3'd3;

  // ===================================================================
  // Memory map
  // ===================================================================
  // CLINT, 64 KB window
  parameter logic [addr_w-1:0] clint_base = 32'h0200_0000;
  parameter logic [addr_w-1:0] clint_mask = 32'hFFFF_0000;
  // Console UART, 4 KB window
  parameter logic [addr_w-1:0] uart_base  = 32'h1000_0000;
  parameter logic [addr_w-1:0] uart_mask  = 32'hFFFF_F000;
  // Data RAM, 1 MB window
  parameter logic [addr_w-1:0] dmem_base  = 32'h8000_0000;
  parameter logic [addr_w-1:0] dmem_mask  = 32'hFFF0_0000;

  // CLINT register offsets inside its window
  parameter logic [15:0] clint_msip_off     = 16'h0000;
  parameter logic [15:0] clint_mtimecmp_off = 16'h4000;
  parameter logic [15:0] clint_mtime_off    = 16'hBFF8;

  // UART register offsets, 16550 numbering
  parameter logic [2:0] uart_thr_off = 3'd0;
  parameter logic [2:0] uart_lsr_off = 3'd5;

  // Line status bits
  parameter int lsr_thr_empty_bit = 5;
  parameter int lsr_tx_idle_bit   = 6;

endpackage

`default_nettype wire

/* source/soc_bus_decoder.sv */
// ===================================================================
// Priority address decoder
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module soc_bus_decoder (
  input  logic                            clk,
  input  logic                            rst_n,
  // Master side
  input  logic                            req_valid,
  input  logic [soc_bus_pkg::addr_w-1:0]  req_addr,
  input  logic [soc_bus_pkg::data_w-1:0]  req_wdata,
  input  logic                            req_we,
  input  logic [2:0]                      req_size,
  output logic                            req_ready,
  output logic [soc_bus_pkg::data_w-1:0]  req_rdata,
  // CLINT
  output logic                            clint_valid,
  output logic [15:0]                     clint_addr,
  output logic [soc_bus_pkg::data_w-1:0]  clint_wdata,
  output logic                            clint_we,
  output logic [2:0]                      clint_size,
  input  logic                            clint_ready,
  input  logic [soc_bus_pkg::data_w-1:0]  clint_rdata,
  // UART
  output logic                            uart_valid,
  output logic [2:0]                      uart_addr,
  output logic [7:0]                      uart_wdata,
  output logic                            uart_we,
  input  logic                            uart_ready,
  input  logic [7:0]                      uart_rdata,
  // DMEM
  output logic                            dmem_valid,
  output logic [soc_bus_pkg::addr_w-1:0]  dmem_addr,
  output logic [soc_bus_pkg::data_w-1:0]  dmem_wdata,
  output logic                            dmem_we,
  output logic [2:0]                      dmem_size,
  input  logic                            dmem_ready,
  input  logic [soc_bus_pkg::data_w-1:0]  dmem_rdata
);

  // One-hot select, bit 0 CLINT, bit 1 UART, bit 2 DMEM
  logic [2:0] sel_now;
  logic [2:0] sel;
  logic [2:0] sel_q;
  logic       hold_q;

  // Window match in priority order
  always_comb begin
    sel_now = 3'b000;
    if ((req_addr & soc_bus_pkg::clint_mask) == soc_bus_pkg::clint_base) begin
      sel_now[0] = 1'b1;
    end else if ((req_addr & soc_bus_pkg::uart_mask) == soc_bus_pkg::uart_base) begin
      sel_now[1] = 1'b1;
    end else if ((req_addr & soc_bus_pkg::dmem_mask) == soc_bus_pkg::dmem_base) begin
      sel_now[2] = 1'b1;
    end
  end

  // A stalled transfer keeps its slave until it completes
  assign sel = hold_q ? sel_q : sel_now;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold_q <= 1'b0;
      sel_q  <= 3'b000;
    end else begin
      hold_q <= req_valid && !req_ready;
      sel_q  <= sel;
    end
  end

  // ===================================================================
  // Request routing, unselected slaves see zeros
  // ===================================================================
  assign clint_valid = req_valid && sel[0];
  assign clint_addr  = sel[0] ? req_addr[15:0] : '0;
  assign clint_wdata = sel[0] ? req_wdata : '0;
  assign clint_we    = sel[0] && req_we;
  assign clint_size  = sel[0] ? req_size : '0;

  // UART is byte wide, size is ignored
  assign uart_valid  = req_valid && sel[1];
  assign uart_addr   = sel[1] ? req_addr[2:0] : '0;
  assign uart_wdata  = sel[1] ? req_wdata[7:0] : '0;
  assign uart_we     = sel[1] && req_we;

  assign dmem_valid  = req_valid && sel[2];
  assign dmem_addr   = sel[2] ? req_addr : '0;
  assign dmem_wdata  = sel[2] ? req_wdata : '0;
  assign dmem_we     = sel[2] && req_we;
  assign dmem_size   = sel[2] ? req_size : '0;

  // Response mux
  always_comb begin
    req_ready = 1'b0;
    req_rdata = '0;
    if (sel[0]) begin
      req_ready = clint_ready;
      req_rdata = clint_rdata;
    end else if (sel[1]) begin
      req_ready = uart_ready;
      req_rdata = {56'h0, uart_rdata};
    end else if (sel[2]) begin
      req_ready = dmem_ready;
      req_rdata = dmem_rdata;
    end else begin
      // Unmapped, complete at once with zero data
      req_ready = req_valid;
    end
  end

endmodule

`default_nettype wire

/* source/data_ram.sv */
// ===================================================================
// Data RAM, doubleword wide
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter int ram_words = 256
) (
  input  logic                            clk,
  input  logic                            valid,
  input  logic [soc_bus_pkg::addr_w-1:0]  addr,
  input  logic [soc_bus_pkg::data_w-1:0]  wdata,
  input  logic                            we,
  input  logic [2:0]                      size,
  output logic                            ready,
  output logic [soc_bus_pkg::data_w-1:0]  rdata
);

  localparam int idx_w = (ram_words > 1) ? $clog2(ram_words) : 1;

  logic [soc_bus_pkg::data_w-1:0] mem [ram_words];
  logic [idx_w-1:0]               idx;
  logic [2:0]                     off;
  logic [2:0]                     lane;
  logic [7:0]                     strb;
  logic [soc_bus_pkg::data_w-1:0] wdata_sh;

  // Doubleword index, upper address bits wrap
  assign idx = addr[3 +: idx_w];
  assign off = addr[2:0];

  // Lane strobes from size and low address bits
  always_comb begin
    case (size)
      soc_bus_pkg::size_byte: begin
        lane = off;
        strb = 8'h01 << lane;
      end
      soc_bus_pkg::size_half: begin
        lane = {off[2:1], 1'b0};
        strb = 8'h03 << lane;
      end
      soc_bus_pkg::size_word: begin
        lane = {off[2], 2'b00};
        strb = 8'h0F << lane;
      end
      default: begin
        lane = 3'd0;
        strb = 8'hFF;
      end
    endcase
    // Low bytes of wdata move up to the first lane
    wdata_sh = wdata << {lane, 3'b000};
  end

  always_ff @(posedge clk) begin
    if (valid && we) begin
      for (int i = 0; i < 8; i++) begin
        if (strb[i]) begin
          mem[idx][i*8 +: 8] <= wdata_sh[i*8 +: 8];
        end
      end
    end
  end

  // Always ready, aligned doubleword read
  assign ready = valid;
  assign rdata = mem[idx];

endmodule

`default_nettype wire

/* source/clint_regs.sv */
// ===================================================================
// CLINT register block
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module clint_regs (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            valid,
  input  logic [15:0]                     addr,
  input  logic [soc_bus_pkg::data_w-1:0]  wdata,
  input  logic                            we,
  input  logic [2:0]                      size,
  output logic                            ready,
  output logic [soc_bus_pkg::data_w-1:0]  rdata,
  output logic                            mtime_load,
  output logic [soc_bus_pkg::data_w-1:0]  mtime_wdata,
  output logic [soc_bus_pkg::data_w-1:0]  mtimecmp,
  input  logic [soc_bus_pkg::data_w-1:0]  mtime,
  output logic                            soft_irq
);

  logic                           msip;
  logic                           hit_msip;
  logic                           hit_cmp;
  logic                           hit_time;
  logic                           hi_half;
  logic                           wr;
  logic [soc_bus_pkg::data_w-1:0] wmask;
  logic [soc_bus_pkg::data_w-1:0] wdata_al;
  logic [soc_bus_pkg::data_w-1:0] rd_reg;

  // Doubleword match, addr[2] picks a half for word accesses
  assign hit_msip = addr[15:3] == soc_bus_pkg::clint_msip_off[15:3];
  assign hit_cmp  = addr[15:3] == soc_bus_pkg::clint_mtimecmp_off[15:3];
  assign hit_time = addr[15:3] == soc_bus_pkg::clint_mtime_off[15:3];
  assign hi_half  = (size != soc_bus_pkg::size_dword) && addr[2];
  assign wr       = valid && we;

  // Narrow writes touch one 32-bit half only
  assign wmask    = (size == soc_bus_pkg::size_dword) ? '1 :
                    hi_half ? {32'hFFFF_FFFF, 32'h0} : {32'h0, 32'hFFFF_FFFF};
  assign wdata_al = (size == soc_bus_pkg::size_dword) ? wdata : {wdata[31:0], wdata[31:0]};

  // mtime lives in the timer, merged value goes across
  assign mtime_load  = wr && hit_time;
  assign mtime_wdata = (mtime & ~wmask) | (wdata_al & wmask);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      msip     <= 1'b0;
      mtimecmp <= '1;
      soft_irq <= 1'b0;
    end else begin
      if (wr && hit_msip && wmask[0]) msip <= wdata_al[0];
      if (wr && hit_cmp) mtimecmp <= (mtimecmp & ~wmask) | (wdata_al & wmask);
      soft_irq <= msip;
    end
  end

  // Read mux, unknown offsets read zero
  always_comb begin
    rd_reg = '0;
    if (hit_msip)      rd_reg = {63'h0, msip};
    else if (hit_cmp)  rd_reg = mtimecmp;
    else if (hit_time) rd_reg = mtime;
  end

  assign rdata = hi_half ? {32'h0, rd_reg[63:32]} : rd_reg;
  assign ready = valid;

endmodule

`default_nettype wire

/* source/clint_timer.sv */
// ===================================================================
// CLINT machine timer
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            mtime_load,
  input  logic [soc_bus_pkg::data_w-1:0]  mtime_wdata,
  input  logic [soc_bus_pkg::data_w-1:0]  mtimecmp,
  output logic [soc_bus_pkg::data_w-1:0]  mtime,
  output logic                            timer_irq
);

  // Free-running counter, a software load wins over the increment
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtime <= '0;
    end else if (mtime_load) begin
      mtime <= mtime_wdata;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  // Compare is registered, level stays while mtime >= mtimecmp
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timer_irq <= 1'b0;
    end else begin
      timer_irq <= (mtime >= mtimecmp);
    end
  end

endmodule

`default_nettype wire

/* source/console_uart.sv */
// ===================================================================
// Console UART, transmit side
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module console_uart #(
  parameter int tx_fifo_depth = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        valid,
  input  logic [2:0]  addr,
  input  logic [7:0]  wdata,
  input  logic        we,
  output logic        ready,
  output logic [7:0]  rdata,
  output logic [7:0]  tx_data,
  output logic        tx_valid,
  input  logic        tx_ready
);

  localparam int ptr_w = (tx_fifo_depth > 1) ? $clog2(tx_fifo_depth) : 1;
  localparam int cnt_w = $clog2(tx_fifo_depth + 1);

  logic [7:0]       fifo_mem [tx_fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             full;
  logic             empty;
  logic             thr_wr;
  logic             push;
  logic             pop;

  assign full   = count == cnt_w'(tx_fifo_depth);
  assign empty  = count == '0;
  assign thr_wr = valid && we && (addr == soc_bus_pkg::uart_thr_off);
  // Push only with space, a pop in the same cycle does not help
  assign push   = thr_wr && !full;
  assign pop    = tx_valid && tx_ready;

  // Reads always complete, THR writes stall on a full FIFO
  assign ready  = valid && !(thr_wr && full);

  always_ff @(posedge clk) begin
    if (push) fifo_mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == ptr_w'(tx_fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == ptr_w'(tx_fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // FIFO head on the byte port
  assign tx_data  = fifo_mem[rd_ptr];
  assign tx_valid = !empty;

  // LSR, other offsets read zero
  always_comb begin
    rdata = 8'h00;
    if (addr == soc_bus_pkg::uart_lsr_off) begin
      rdata[soc_bus_pkg::lsr_thr_empty_bit] = !full;
      rdata[soc_bus_pkg::lsr_tx_idle_bit]   = empty;
    end
  end

endmodule

`default_nettype wire

/* source/soc_bus_top.sv */
// ===================================================================
// Peripheral bus top level
// ===================================================================
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top #(
  parameter int ram_words     = 256,
  parameter int tx_fifo_depth = 4
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            req_valid,
  input  logic [soc_bus_pkg::addr_w-1:0]  req_addr,
  input  logic [soc_bus_pkg::data_w-1:0]  req_wdata,
  input  logic                            req_we,
  input  logic [2:0]                      req_size,
  output logic                            req_ready,
  output logic [soc_bus_pkg::data_w-1:0]  req_rdata,
  output logic [7:0]                      tx_data,
  output logic                            tx_valid,
  input  logic                            tx_ready,
  output logic                            timer_irq,
  output logic                            soft_irq
);

  // Decoder to CLINT
  logic                           clint_valid;
  logic [15:0]                    clint_addr;
  logic [soc_bus_pkg::data_w-1:0] clint_wdata;
  logic                           clint_we;
  logic [2:0]                     clint_size;
  logic                           clint_ready;
  logic [soc_bus_pkg::data_w-1:0] clint_rdata;
  // Decoder to UART
  logic                           uart_valid;
  logic [2:0]                     uart_addr;
  logic [7:0]                     uart_wdata;
  logic                           uart_we;
  logic                           uart_ready;
  logic [7:0]                     uart_rdata;
  // Decoder to DMEM
  logic                           dmem_valid;
  logic [soc_bus_pkg::addr_w-1:0] dmem_addr;
  logic [soc_bus_pkg::data_w-1:0] dmem_wdata;
  logic                           dmem_we;
  logic [2:0]                     dmem_size;
  logic                           dmem_ready;
  logic [soc_bus_pkg::data_w-1:0] dmem_rdata;
  // CLINT registers to timer
  logic                           mtime_load;
  logic [soc_bus_pkg::data_w-1:0] mtime_wdata;
  logic [soc_bus_pkg::data_w-1:0] mtimecmp;
  logic [soc_bus_pkg::data_w-1:0] mtime;

  soc_bus_decoder decoder_i (
    .clk(clk), .rst_n(rst_n),
    .req_valid(req_valid), .req_addr(req_addr), .req_wdata(req_wdata),
    .req_we(req_we), .req_size(req_size),
    .req_ready(req_ready), .req_rdata(req_rdata),
    .clint_valid(clint_valid), .clint_addr(clint_addr), .clint_wdata(clint_wdata),
    .clint_we(clint_we), .clint_size(clint_size),
    .clint_ready(clint_ready), .clint_rdata(clint_rdata),
    .uart_valid(uart_valid), .uart_addr(uart_addr), .uart_wdata(uart_wdata),
    .uart_we(uart_we), .uart_ready(uart_ready), .uart_rdata(uart_rdata),
    .dmem_valid(dmem_valid), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_we(dmem_we), .dmem_size(dmem_size),
    .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata)
  );

  data_ram #(.ram_words(ram_words)) dmem_i (
    .clk(clk), .valid(dmem_valid), .addr(dmem_addr), .wdata(dmem_wdata),
    .we(dmem_we), .size(dmem_size), .ready(dmem_ready), .rdata(dmem_rdata)
  );

  clint_regs clint_regs_i (
    .clk(clk), .rst_n(rst_n),
    .valid(clint_valid), .addr(clint_addr), .wdata(clint_wdata),
    .we(clint_we), .size(clint_size), .ready(clint_ready), .rdata(clint_rdata),
    .mtime_load(mtime_load), .mtime_wdata(mtime_wdata), .mtimecmp(mtimecmp),
    .mtime(mtime), .soft_irq(soft_irq)
  );

  clint_timer clint_timer_i (
    .clk(clk), .rst_n(rst_n),
    .mtime_load(mtime_load), .mtime_wdata(mtime_wdata), .mtimecmp(mtimecmp),
    .mtime(mtime), .timer_irq(timer_irq)
  );

  console_uart #(.tx_fifo_depth(tx_fifo_depth)) uart_i (
    .clk(clk), .rst_n(rst_n),
    .valid(uart_valid), .addr(uart_addr), .wdata(uart_wdata), .we(uart_we),
    .ready(uart_ready), .rdata(uart_rdata),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready)
  );

endmodule

`default_nettype wire

/* tests/tb_soc_bus.sv */
// ======================================================================
// Peripheral bus testbench
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

  localparam int max_vectors   = 64;
  localparam int ready_timeout = 50;
  localparam int drain_timeout = 200;

  logic                           clk;
  logic                           rst_n;
  logic                           req_valid;
  logic [soc_bus_pkg::addr_w-1:0] req_addr;
  logic [soc_bus_pkg::data_w-1:0] req_wdata;
  logic                           req_we;
  logic [2:0]                     req_size;
  logic                           req_ready;
  logic [soc_bus_pkg::data_w-1:0] req_rdata;
  logic [7:0]                     tx_data;
  logic                           tx_valid;
  logic                           tx_ready;
  logic                           timer_irq;
  logic                           soft_irq;

  // Five words per vector: op, addr, data, size, expected
  logic [63:0] vec_mem [5*max_vectors];
  // Bytes accepted by THR, oldest first
  logic [7:0]  tx_expect [$];
  int          error_count;
  int          check_count;
  bit          timed_out;

  soc_bus_top #(.ram_words(256), .tx_fifo_depth(4)) dut_i (
    .clk(clk), .rst_n(rst_n),
    .req_valid(req_valid), .req_addr(req_addr), .req_wdata(req_wdata),
    .req_we(req_we), .req_size(req_size),
    .req_ready(req_ready), .req_rdata(req_rdata),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
    .timer_irq(timer_irq), .soft_irq(soft_irq)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("ERROR %0t: %s got 0x%h, expected 0x%h", $time, what, got, exp);
    end
  endtask

  // THR register inside the UART window
  function automatic bit addresses_thr(input logic [31:0] addr);
    return ((addr & soc_bus_pkg::uart_mask) == soc_bus_pkg::uart_base) &&
           (addr[2:0] == soc_bus_pkg::uart_thr_off);
  endfunction

  // ======================================================================
  // Bus master tasks
  // ======================================================================
  task automatic start_request(input logic [31:0] addr, input logic [63:0] data,
                               input logic we, input logic [2:0] size);
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr  <= addr;
    req_wdata <= data;
    req_we    <= we;
    req_size  <= size;
  endtask

  // Ready is sampled at the falling edge, transfer ends at the next rise
  task automatic finish_request(input logic [31:0] addr, output logic [63:0] rdata);
    bit done;
    done  = 1'b0;
    rdata = '0;
    for (int cyc = 0; cyc < ready_timeout && !done; cyc++) begin
      @(negedge clk);
      if (req_ready) begin
        done  = 1'b1;
        rdata = req_rdata;
      end
      @(posedge clk);
    end
    req_valid <= 1'b0;
    req_addr  <= '0;
    req_wdata <= '0;
    req_we    <= 1'b0;
    req_size  <= '0;
    if (!done) begin
      timed_out = 1'b1;
      $display("Request to 0x%08h did not complete within %0d cycles", addr, ready_timeout);
    end
  endtask

  task automatic bus_access(input logic [31:0] addr, input logic [63:0] data,
                            input logic we, input logic [2:0] size,
                            output logic [63:0] rdata);
    start_request(addr, data, we, size);
    finish_request(addr, rdata);
    if (we && !timed_out && addresses_thr(addr)) begin
      tx_expect.push_back(data[7:0]);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  // Wait until the transmit FIFO reports empty
  task automatic drain_tx();
    bit empty_seen;
    empty_seen = 1'b0;
    for (int cyc = 0; cyc < drain_timeout && !empty_seen; cyc++) begin
      @(negedge clk);
      if (!tx_valid) empty_seen = 1'b1;
    end
    if (!empty_seen) begin
      timed_out = 1'b1;
      $display("Transmit FIFO did not drain within %0d cycles", drain_timeout);
    end else begin
      check_value("bytes still expected on tx", 64'(tx_expect.size()), 64'h0);
    end
  endtask

  task automatic set_tx_ready(input logic level);
    @(posedge clk);
    tx_ready <= level;
    if (level) drain_tx();
  endtask

  // THR write into a full FIFO, must stall until tx_ready frees a slot
  task automatic stalled_write(input logic [31:0] addr, input logic [63:0] data,
                               input int stall_cycles);
    logic [63:0] unused_rdata;
    start_request(addr, data, 1'b1, soc_bus_pkg::size_byte);
    for (int cyc = 0; cyc < stall_cycles; cyc++) begin
      @(negedge clk);
      check_value("ready during full FIFO", {63'h0, req_ready}, 64'h0);
      @(posedge clk);
    end
    tx_ready <= 1'b1;
    finish_request(addr, unused_rdata);
    if (!timed_out) tx_expect.push_back(data[7:0]);
    drain_tx();
  endtask

  // ======================================================================
  // Transmit scoreboard
  // ======================================================================
  // A byte seen here leaves on the next rising edge
  always @(negedge clk) begin
    if (rst_n && tx_valid && tx_ready) begin
      check_count++;
      assert (tx_expect.size() > 0) else begin
        error_count++;
        $display("ERROR %0t: tx byte 0x%02h with no THR write pending", $time, tx_data);
      end
      if (tx_expect.size() > 0) begin
        check_value("tx byte", {56'h0, tx_data}, {56'h0, tx_expect.pop_front()});
      end
    end
  end

  initial begin
    logic [63:0] op;
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] size;
    logic [63:0] expect_val;
    logic [63:0] rdata;
    int          idx;
    clk         = 1'b0;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req_addr    = '0;
    req_wdata   = '0;
    req_we      = 1'b0;
    req_size    = '0;
    tx_ready    = 1'b0;
    error_count = 0;
    check_count = 0;
    timed_out   = 1'b0;
    $readmemh("tests/soc_bus_vectors.txt", vec_mem);
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    idx = 0;
    while (idx < max_vectors && !timed_out && vec_mem[5*idx] != 64'hF) begin
      op         = vec_mem[5*idx];
      addr       = vec_mem[5*idx+1];
      data       = vec_mem[5*idx+2];
      size       = vec_mem[5*idx+3];
      expect_val = vec_mem[5*idx+4];
      case (op[3:0])
        4'h0: bus_access(addr[31:0], data, 1'b1, size[2:0], rdata);
        4'h1: begin
          bus_access(addr[31:0], data, 1'b0, size[2:0], rdata);
          check_value($sformatf("read 0x%08h", addr[31:0]), rdata, expect_val);
        end
        4'h2: begin
          idle_cycles(int'(data));
          // Levels packed as tx_valid, soft_irq, timer_irq
          check_value("tx_valid and irq levels", {61'h0, tx_valid, soft_irq, timer_irq},
                      expect_val);
        end
        4'h3: set_tx_ready(data[0]);
        4'h4: stalled_write(addr[31:0], data, int'(expect_val));
        default: begin
          error_count++;
          $display("Unknown operation %0h in vector %0d", op, idx);
        end
      endcase
      idx++;
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timed_out);
    if (error_count == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/soc_bus_vectors.txt */
// Columns: op addr data size expected, all hex, size 0..3 is byte..dword
// op 0 write, 1 read and compare, 2 idle data cycles then compare {tx_valid, soft_irq,
// timer_irq}, 3 set tx_ready to data bit 0, 4 THR write stalled for expected cycles, f end
// Levels and mtimecmp straight after reset
2 00000000 0 0 0
1 02004000 0 3 ffffffffffffffff
// DMEM lane merging
0 80000000 1122334455667788 3 0
0 80000004 0badf00d 2 0
0 80000002 beef 1 0
0 80000007 5a 0 0
0 80000000 11 0 0
1 80000000 0 3 5aadf00dbeef7711
1 80000005 0 0 5aadf00dbeef7711
0 80000808 cafef00d12345678 3 0
1 80000008 0 3 cafef00d12345678
// Unmapped, old PLIC and IMEM windows, past DMEM and past CLINT
1 0c000000 0 3 0
1 20000000 0 3 0
0 0c000000 ffffffffffffffff 3 0
0 80100000 ffffffffffffffff 3 0
0 02014000 0 3 0
1 80000000 0 3 5aadf00dbeef7711
1 02004000 0 3 ffffffffffffffff
// CLINT registers and interrupt levels
0 02004000 123456789abcdef0 3 0
1 02004000 0 3 123456789abcdef0
1 02004004 0 2 12345678
0 02000000 1 2 0
1 02000000 0 2 1
2 00000000 3 0 2
0 02004000 0 3 0
2 00000000 3 0 3
0 02004000 ffffffffffffffff 3 0
0 02000000 0 2 0
2 00000000 3 0 0
// UART with tx_ready low, four byte FIFO
1 10000005 0 0 60
1 10000002 0 0 0
0 10000000 41 0 0
0 10000000 42 0 0
0 10000000 43 0 0
0 10000000 44 0 0
1 10000005 0 0 0
4 10000000 45 0 8
1 10000005 0 0 60
3 00000000 0 0 0
f 00000000 0 0 0

/* build.f */
source/soc_bus_pkg.sv
source/soc_bus_decoder.sv
source/data_ram.sv
source/clint_regs.sv
source/clint_timer.sv
source/console_uart.sv
source/soc_bus_top.sv
tests/tb_soc_bus.sv

/* Makefile */
# Verilator build and run for the peripheral bus testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
